// File: logic/csr_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR package
// Shared types, machine CSR addresses and field positions
// for the machine-mode CSR path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package csr_pkg;

  localparam int XLEN = 32;

  // CSR operation after decode
  typedef enum logic [1:0] {
    CSR_NONE  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_t;

  // SYSTEM funct3 encodings for the CSR instructions
  typedef enum logic [2:0] {
    F3_CSRRW  = 3'b001,
    F3_CSRRS  = 3'b010,
    F3_CSRRC  = 3'b011,
    F3_CSRRWI = 3'b101,
    F3_CSRRSI = 3'b110,
    F3_CSRRCI = 3'b111
  } csr_funct3_e;

  typedef enum logic [11:0] {
    MSTATUS_ADDR       = 12'h300,
    MISA_ADDR          = 12'h301,
    MIE_ADDR           = 12'h304,
    MTVEC_ADDR         = 12'h305,
    MCOUNTEREN_ADDR    = 12'h306,
    MSTATUSH_ADDR      = 12'h310,
    MCOUNTINHIBIT_ADDR = 12'h320,
    MSCRATCH_ADDR      = 12'h340,
    MEPC_ADDR          = 12'h341,
    MCAUSE_ADDR        = 12'h342,
    MTVAL_ADDR         = 12'h343,
    MIP_ADDR           = 12'h344,
    MCYCLE_ADDR        = 12'hB00,
    MINSTRET_ADDR      = 12'hB02,
    MCYCLEH_ADDR       = 12'hB80,
    MVENDORID_ADDR     = 12'hF11,
    MARCHID_ADDR       = 12'hF12,
    MIMPID_ADDR        = 12'hF13,
    MHARTID_ADDR       = 12'hF14,
    MCONFIGPTR_ADDR    = 12'hF15,
    MINSTRETH_ADDR     = 12'hB82
  } csr_addr_e;

  typedef enum logic [1:0] {
    U_MODE        = 2'b00,
    S_MODE        = 2'b01,
    RESERVED_MODE = 2'b10,
    M_MODE        = 2'b11
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'b00,
    VECTORED = 2'b01
  } mtvec_mode_t;

  localparam logic [XLEN-1:0] HARTID     = '0;
  localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100; // MXL=1, I only

  // Bit positions of the implemented fields
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_MPP  = 11;  // Low bit of the 2-bit field
  localparam int MSTATUS_MPRV = 17;
  localparam int MSTATUS_TW   = 21;
  localparam int MIX_MSI      = 3;   // Shared by mie and mip
  localparam int MIX_MTI      = 7;
  localparam int MIX_MEI      = 11;
  localparam int CNT_CY       = 0;
  localparam int CNT_IR       = 2;

endpackage

// File: logic/csr_cmd_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR command interface
// Decoded CSR request passed from decode to execute
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface csr_cmd_if;
  logic                         valid;
  csr_pkg::csr_op_t             op;
  logic [11:0]                  addr;
  logic [csr_pkg::XLEN-1:0]     operand;
  logic                         wr_en;
  logic                         op_fault;  // Reserved funct3
  logic                         ro_fault;  // Write to a read-only address

  modport decode (output valid, op, addr, operand, wr_en, op_fault, ro_fault);
  modport execute (input valid, op, addr, operand, wr_en, op_fault, ro_fault);
  modport respond (input valid, op_fault, ro_fault);

endinterface

// File: logic/csr_access_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR access interface
// Links execute, the CSR file and the response stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface csr_access_if;
  logic [11:0]                  addr;
  logic                         mod;       // Write request into the file
  logic [csr_pkg::XLEN-1:0]     new_val;
  logic [csr_pkg::XLEN-1:0]     old_val;
  logic                         invalid;   // Privilege or unknown address
  csr_pkg::priv_level_t         curr_priv;
  logic                         inst_ret;

  modport execute (output addr, mod, new_val, input old_val);

  modport file (
    input  addr, mod, new_val, curr_priv, inst_ret,
    output old_val, invalid
  );

  modport respond (input old_val, invalid);

endinterface

// File: logic/csr_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR decode
// Turns funct3 and rs1 into an operation, operand and write
// intent, and flags reserved or read-only accesses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module csr_decode (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        req,
  input  logic [2:0]  funct3,
  input  logic [4:0]  rs1_idx,
  input  logic [31:0] rs1_data,
  input  logic [11:0] csr_addr,
  csr_cmd_if.decode   cmd
);

  csr_pkg::csr_op_t op;
  logic             op_fault;
  logic             imm_form;

  always_comb begin
    op       = csr_pkg::CSR_NONE;
    op_fault = 1'b0;
    case (funct3)
      csr_pkg::F3_CSRRW, csr_pkg::F3_CSRRWI: op = csr_pkg::CSR_WRITE;
      csr_pkg::F3_CSRRS, csr_pkg::F3_CSRRSI: op = csr_pkg::CSR_SET;
      csr_pkg::F3_CSRRC, csr_pkg::F3_CSRRCI: op = csr_pkg::CSR_CLEAR;
      default: op_fault = 1'b1;  // 000 and 100
    endcase
  end

  assign imm_form = funct3[2];

  assign cmd.valid    = req;
  assign cmd.op       = op;
  assign cmd.addr     = csr_addr;
  assign cmd.op_fault = op_fault;
  assign cmd.operand  = imm_form ? {{(csr_pkg::XLEN-5){1'b0}}, rs1_idx} : rs1_data;

  // Set and clear with x0 or a zero immediate read without writing
  assign cmd.wr_en = (op == csr_pkg::CSR_WRITE) ||
                     (((op == csr_pkg::CSR_SET) || (op == csr_pkg::CSR_CLEAR)) &&
                      (rs1_idx != 5'd0));

  // Top two address bits of 11 mark a read-only CSR
  assign cmd.ro_fault = cmd.wr_en && (csr_addr[11:10] == 2'b11);

endmodule

// File: logic/csr_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR execute
// Forms the new CSR value for write, set or clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module csr_execute (
  csr_cmd_if.execute    cmd,
  csr_access_if.execute acc
);

  logic [csr_pkg::XLEN-1:0] new_val;

  always_comb begin
    case (cmd.op)
      csr_pkg::CSR_WRITE: new_val = cmd.operand;
      csr_pkg::CSR_SET:   new_val = acc.old_val | cmd.operand;
      csr_pkg::CSR_CLEAR: new_val = acc.old_val & ~cmd.operand;
      default:            new_val = acc.old_val;  // No operation, keep value
    endcase
  end

  assign acc.addr    = cmd.addr;
  assign acc.new_val = new_val;

  // A faulting request never reaches the register file
  assign acc.mod = cmd.valid && cmd.wr_en && !cmd.op_fault && !cmd.ro_fault;

endmodule

// File: logic/csr_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine CSR file
// Holds the machine CSRs, checks privilege and address,
// applies WARL rules and runs the cycle and instret counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module csr_file (
  input  logic       CLK,
  input  logic       nRST,
  csr_access_if.file acc
);

  // mstatus fields
  logic                     mstatus_mie;
  logic                     mstatus_mpie;
  csr_pkg::priv_level_t     mstatus_mpp;
  logic                     mstatus_mprv;
  logic                     mstatus_tw;
  // mie and mip keep the three machine bits
  logic                     mie_msie, mie_mtie, mie_meie;
  logic                     mip_msip, mip_mtip, mip_meip;
  logic [csr_pkg::XLEN-1:3] mtvec_base;
  csr_pkg::mtvec_mode_t     mtvec_mode;
  logic [csr_pkg::XLEN-1:0] mscratch;
  logic [csr_pkg::XLEN-1:0] mepc;
  logic [csr_pkg::XLEN-1:0] mcause;
  logic [csr_pkg::XLEN-1:0] mcounteren;
  logic [csr_pkg::XLEN-1:0] mcountinhibit;
  logic [63:0]              cycle_cnt, cycle_next;
  logic [63:0]              instret_cnt, instret_next;

  logic [csr_pkg::XLEN-1:0] nxt_val;     // New value after WARL fixes
  logic [csr_pkg::XLEN-1:0] mstatus_rd;
  logic [csr_pkg::XLEN-1:0] mie_rd, mip_rd;
  logic                     wr_ok;

  assign wr_ok = acc.mod && !acc.invalid;

  // Privilege check, address existence and legal values
  always_comb begin
    nxt_val     = acc.new_val;
    acc.invalid = 1'b0;
    if (acc.addr[9:8] > acc.curr_priv) begin
      acc.invalid = 1'b1;  // Not enough privilege
    end else begin
      case (acc.addr)
        csr_pkg::MSTATUS_ADDR: begin
          if (acc.new_val[csr_pkg::MSTATUS_MPP +: 2] == csr_pkg::RESERVED_MODE)
            nxt_val[csr_pkg::MSTATUS_MPP +: 2] = csr_pkg::U_MODE;
        end
        csr_pkg::MTVEC_ADDR: begin
          if (acc.new_val[1:0] > csr_pkg::VECTORED)
            nxt_val[1:0] = csr_pkg::DIRECT;
        end
        csr_pkg::MVENDORID_ADDR, csr_pkg::MARCHID_ADDR, csr_pkg::MIMPID_ADDR,
        csr_pkg::MHARTID_ADDR, csr_pkg::MCONFIGPTR_ADDR, csr_pkg::MISA_ADDR,
        csr_pkg::MIE_ADDR, csr_pkg::MSTATUSH_ADDR, csr_pkg::MSCRATCH_ADDR,
        csr_pkg::MEPC_ADDR, csr_pkg::MCAUSE_ADDR, csr_pkg::MTVAL_ADDR,
        csr_pkg::MIP_ADDR, csr_pkg::MCOUNTEREN_ADDR, csr_pkg::MCOUNTINHIBIT_ADDR,
        csr_pkg::MCYCLE_ADDR, csr_pkg::MINSTRET_ADDR, csr_pkg::MCYCLEH_ADDR,
        csr_pkg::MINSTRETH_ADDR: ;  // No legal-value rule
        default: acc.invalid = 1'b1;  // Unknown CSR
      endcase
    end
  end

  // A CSR write to a counter half wins over the increment
  always_comb begin
    cycle_next   = cycle_cnt;
    instret_next = instret_cnt;
    if (!mcountinhibit[csr_pkg::CNT_CY]) cycle_next = cycle_cnt + 64'd1;
    if (!mcountinhibit[csr_pkg::CNT_IR]) instret_next = instret_cnt + {63'd0, acc.inst_ret};
    if (wr_ok) begin
      case (acc.addr)
        csr_pkg::MCYCLE_ADDR:    cycle_next[31:0]    = nxt_val;
        csr_pkg::MCYCLEH_ADDR:   cycle_next[63:32]   = nxt_val;
        csr_pkg::MINSTRET_ADDR:  instret_next[31:0]  = nxt_val;
        csr_pkg::MINSTRETH_ADDR: instret_next[63:32] = nxt_val;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_mie   <= 1'b0;
      mstatus_mpie  <= 1'b0;
      mstatus_mpp   <= csr_pkg::M_MODE;
      mstatus_mprv  <= 1'b0;
      mstatus_tw    <= 1'b0;
      mie_msie      <= 1'b0;
      mie_mtie      <= 1'b0;
      mie_meie      <= 1'b0;
      mip_msip      <= 1'b0;
      mip_mtip      <= 1'b0;
      mip_meip      <= 1'b0;
      mtvec_base    <= '0;
      mtvec_mode    <= csr_pkg::DIRECT;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mcounteren    <= '0;
      mcountinhibit <= '1;  // Counters start stopped
      cycle_cnt     <= '0;
      instret_cnt   <= '0;
    end else begin
      if (wr_ok) begin
        case (acc.addr)
          csr_pkg::MSTATUS_ADDR: begin
            mstatus_mie  <= nxt_val[csr_pkg::MSTATUS_MIE];
            mstatus_mpie <= nxt_val[csr_pkg::MSTATUS_MPIE];
            mstatus_mpp  <= csr_pkg::priv_level_t'(nxt_val[csr_pkg::MSTATUS_MPP +: 2]);
            mstatus_mprv <= nxt_val[csr_pkg::MSTATUS_MPRV];
            mstatus_tw   <= nxt_val[csr_pkg::MSTATUS_TW];
          end
          csr_pkg::MIE_ADDR: begin
            mie_msie <= nxt_val[csr_pkg::MIX_MSI];
            mie_mtie <= nxt_val[csr_pkg::MIX_MTI];
            mie_meie <= nxt_val[csr_pkg::MIX_MEI];
          end
          csr_pkg::MIP_ADDR: begin
            mip_msip <= nxt_val[csr_pkg::MIX_MSI];
            mip_mtip <= nxt_val[csr_pkg::MIX_MTI];
            mip_meip <= nxt_val[csr_pkg::MIX_MEI];
          end
          csr_pkg::MTVEC_ADDR: begin
            mtvec_base <= nxt_val[csr_pkg::XLEN-1:3];
            mtvec_mode <= csr_pkg::mtvec_mode_t'(nxt_val[1:0]);
          end
          csr_pkg::MSCRATCH_ADDR:      mscratch      <= nxt_val;
          csr_pkg::MEPC_ADDR:          mepc          <= nxt_val;
          csr_pkg::MCAUSE_ADDR:        mcause        <= nxt_val;
          csr_pkg::MCOUNTEREN_ADDR:    mcounteren    <= nxt_val;
          csr_pkg::MCOUNTINHIBIT_ADDR: mcountinhibit <= nxt_val;
          default: ;  // Read-only or ignored registers such as mtval
        endcase
      end
      cycle_cnt   <= cycle_next;
      instret_cnt <= instret_next;
    end
  end

  // Read views with unimplemented bits at zero
  always_comb begin
    mstatus_rd = '0;
    mstatus_rd[csr_pkg::MSTATUS_MIE]      = mstatus_mie;
    mstatus_rd[csr_pkg::MSTATUS_MPIE]     = mstatus_mpie;
    mstatus_rd[csr_pkg::MSTATUS_MPP +: 2] = mstatus_mpp;
    mstatus_rd[csr_pkg::MSTATUS_MPRV]     = mstatus_mprv;
    mstatus_rd[csr_pkg::MSTATUS_TW]       = mstatus_tw;
    mie_rd = '0;
    mie_rd[csr_pkg::MIX_MSI] = mie_msie;
    mie_rd[csr_pkg::MIX_MTI] = mie_mtie;
    mie_rd[csr_pkg::MIX_MEI] = mie_meie;
    mip_rd = '0;
    mip_rd[csr_pkg::MIX_MSI] = mip_msip;
    mip_rd[csr_pkg::MIX_MTI] = mip_mtip;
    mip_rd[csr_pkg::MIX_MEI] = mip_meip;
  end

  always_comb begin
    case (acc.addr)
      csr_pkg::MSTATUS_ADDR:       acc.old_val = mstatus_rd;
      csr_pkg::MISA_ADDR:          acc.old_val = csr_pkg::MISA_VALUE;
      csr_pkg::MIE_ADDR:           acc.old_val = mie_rd;
      csr_pkg::MIP_ADDR:           acc.old_val = mip_rd;
      csr_pkg::MTVEC_ADDR:         acc.old_val = {mtvec_base, 1'b0, mtvec_mode};
      csr_pkg::MSCRATCH_ADDR:      acc.old_val = mscratch;
      csr_pkg::MEPC_ADDR:          acc.old_val = mepc;
      csr_pkg::MCAUSE_ADDR:        acc.old_val = mcause;
      csr_pkg::MCOUNTEREN_ADDR:    acc.old_val = mcounteren;
      csr_pkg::MCOUNTINHIBIT_ADDR: acc.old_val = mcountinhibit;
      csr_pkg::MCYCLE_ADDR:        acc.old_val = cycle_cnt[31:0];
      csr_pkg::MCYCLEH_ADDR:       acc.old_val = cycle_cnt[63:32];
      csr_pkg::MINSTRET_ADDR:      acc.old_val = instret_cnt[31:0];
      csr_pkg::MINSTRETH_ADDR:     acc.old_val = instret_cnt[63:32];
      csr_pkg::MHARTID_ADDR:       acc.old_val = csr_pkg::HARTID;
      default:                     acc.old_val = '0;  // ID regs, mstatush, mtval
    endcase
  end

endmodule

// File: logic/csr_respond.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR response
// Registers the read data, illegal flag and valid strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module csr_respond (
  input  logic          CLK,
  input  logic          nRST,
  csr_access_if.respond acc,
  csr_cmd_if.respond    cmd,
  output logic          rsp_valid,
  output logic          rsp_illegal,
  output logic [31:0]   rsp_rdata
);

  logic illegal;

  assign illegal = acc.invalid || cmd.op_fault || cmd.ro_fault;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rsp_valid   <= 1'b0;
      rsp_illegal <= 1'b0;
    end else begin
      rsp_valid   <= cmd.valid;
      rsp_illegal <= cmd.valid && illegal;  // Quiet between requests
    end
  end

  // Old value before the write, zero on an illegal access
  always_ff @(posedge CLK) begin
    rsp_rdata <= illegal ? '0 : acc.old_val;
  end

endmodule

// File: logic/csr_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR unit
// Machine-mode CSR path: decode, execute, CSR file and the
// registered response, one cycle from request to response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module csr_unit (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        req,
  input  logic [2:0]  funct3,
  input  logic [4:0]  rs1_idx,
  input  logic [31:0] rs1_data,
  input  logic [11:0] csr_addr,
  input  logic [1:0]  curr_priv,
  input  logic        inst_ret,
  output logic        rsp_valid,
  output logic [31:0] rsp_rdata,
  output logic        rsp_illegal
);

  csr_cmd_if    cmd_if ();
  csr_access_if acc_if ();

  assign acc_if.curr_priv = csr_pkg::priv_level_t'(curr_priv);
  assign acc_if.inst_ret  = inst_ret;

  csr_decode i_csr_decode (
    .CLK      (CLK),
    .nRST     (nRST),
    .req      (req),
    .funct3   (funct3),
    .rs1_idx  (rs1_idx),
    .rs1_data (rs1_data),
    .csr_addr (csr_addr),
    .cmd      (cmd_if.decode)
  );

  csr_execute i_csr_execute (
    .cmd (cmd_if.execute),
    .acc (acc_if.execute)
  );

  csr_file i_csr_file (
    .CLK  (CLK),
    .nRST (nRST),
    .acc  (acc_if.file)
  );

  csr_respond i_csr_respond (
    .CLK         (CLK),
    .nRST        (nRST),
    .acc         (acc_if.respond),
    .cmd         (cmd_if.respond),
    .rsp_valid   (rsp_valid),
    .rsp_illegal (rsp_illegal),
    .rsp_rdata   (rsp_rdata)
  );

endmodule

// File: verif/csr_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR unit testbench
// Reads requests and expected responses from the case file,
// drives them back to back and checks each response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module csr_unit_tb;

  localparam int HALF_PERIOD = 50;  // 100 ns clock
  localparam int DRIVE_DELAY = 10;  // Inputs change after the rising edge
  localparam int RSP_TIMEOUT = 5;   // Cycles to wait for rsp_valid

  logic        CLK;
  logic        nRST;
  logic        req;
  logic [2:0]  funct3;
  logic [4:0]  rs1_idx;
  logic [31:0] rs1_data;
  logic [11:0] csr_addr;
  logic [1:0]  curr_priv;
  logic        inst_ret;
  logic        rsp_valid;
  logic [31:0] rsp_rdata;
  logic        rsp_illegal;

  int                fd;
  int                num_fields;
  int                num_cases;
  string             line;
  logic [8*24-1:0]   case_name;
  logic [31:0]       case_f3, case_idx, case_data, case_addr;
  logic [31:0]       case_priv, case_ret, exp_rdata, exp_illegal;

  csr_unit i_csr_unit (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (req),
    .funct3      (funct3),
    .rs1_idx     (rs1_idx),
    .rs1_data    (rs1_data),
    .csr_addr    (csr_addr),
    .curr_priv   (curr_priv),
    .inst_ret    (inst_ret),
    .rsp_valid   (rsp_valid),
    .rsp_rdata   (rsp_rdata),
    .rsp_illegal (rsp_illegal)
  );

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  task automatic check_value(input logic [8*24-1:0] name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %0s %0s expected 0x%08h actual 0x%08h", name, field, expected, actual);
      $display("Regression failed");
      $fatal(1, "Response mismatch");
    end
  endtask

  // Called a little after a rising edge; returns at the same point of a later cycle
  task automatic run_request(input logic [8*24-1:0] name);
    int waited;
    req       = 1'b1;
    funct3    = case_f3[2:0];
    rs1_idx   = case_idx[4:0];
    rs1_data  = case_data;
    csr_addr  = case_addr[11:0];
    curr_priv = case_priv[1:0];
    inst_ret  = case_ret[0];
    @(posedge CLK);
    #DRIVE_DELAY;
    req      = 1'b0;
    inst_ret = 1'b0;  // Only counted in the request cycle
    waited   = 0;
    while (rsp_valid !== 1'b1 && waited < RSP_TIMEOUT) begin
      @(posedge CLK);
      #DRIVE_DELAY;
      waited++;
    end
    if (rsp_valid !== 1'b1) begin
      $display("No response from the DUT for case %0s within %0d cycles", name, RSP_TIMEOUT);
      $display("Regression failed");
      $fatal(1, "Response timeout");
    end else begin
      check_value(name, "rdata", exp_rdata, rsp_rdata);
      check_value(name, "illegal", exp_illegal, {31'd0, rsp_illegal});
    end
  endtask

  initial begin
    nRST      = 1'b0;
    req       = 1'b0;
    funct3    = 3'd0;
    rs1_idx   = 5'd0;
    rs1_data  = 32'd0;
    csr_addr  = 12'd0;
    curr_priv = 2'b11;
    inst_ret  = 1'b0;
    num_cases = 0;
    repeat (2) @(posedge CLK);
    #DRIVE_DELAY;
    nRST = 1'b1;
    check_value("reset", "valid", 32'd0, {31'd0, rsp_valid});

    fd = $fopen("verif/csr_unit_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file verif/csr_unit_cases.txt");
      $display("Regression failed");
      $fatal(1, "Missing case file");
    end else begin
      // Each new request goes out while the previous response is shown
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          num_fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h", case_name, case_f3,
                               case_idx, case_data, case_addr, case_priv, case_ret,
                               exp_rdata, exp_illegal);
          if (num_fields != 9) begin
            $display("Case file line has %0d fields instead of 9: %s", num_fields, line);
            $display("Regression failed");
            $fatal(1, "Bad case file");
          end else begin
            run_request(case_name);
            num_cases++;
          end
        end
      end
      $fclose(fd);
      if (num_cases == 0) begin
        $display("The case file holds no cases");
        $display("Regression failed");
        $fatal(1, "Empty case file");
      end else begin
        @(posedge CLK);
        #DRIVE_DELAY;
        check_value("idle", "valid", 32'd0, {31'd0, rsp_valid});  // Strobe lasts one cycle
        $display("Ran %0d cases", num_cases);
        $display("Regression passed");
        $finish;
      end
    end
  end

endmodule

// File: verif/csr_unit_cases.txt
# name funct3 rs1_idx rs1_data csr_addr curr_priv inst_ret exp_rdata exp_illegal
# all numbers hex, exp_rdata is the CSR value before the request
rw_scratch      1 01 a5a55a5a 340 3 0 00000000 0
rs_scratch      2 02 000000f0 340 3 0 a5a55a5a 0
rc_scratch      3 03 a0000000 340 3 0 a5a55afa 0
rwi_scratch     5 13 00000000 340 3 0 05a55afa 0
rsi_scratch     6 0c 00000000 340 3 0 00000013 0
rci_scratch     7 05 00000000 340 3 0 0000001f 0
rs_x0_scratch   2 00 ffffffff 340 3 0 0000001a 0
rc_x0_scratch   3 00 ffffffff 340 3 0 0000001a 0
rd_scratch      2 00 00000000 340 3 0 0000001a 0
wr_mstatus      1 01 80001089 300 3 0 00001800 0
rd_mstatus      2 00 00000000 300 3 0 00000088 0
wr_mtvec        1 01 80000103 305 3 0 00000000 0
rd_mtvec        2 00 00000000 305 3 0 80000100 0
bad_addr        2 00 00000000 7c0 3 0 00000000 1
user_priv       1 05 deadbeef 340 0 0 00000000 1
bad_funct3      0 05 12345678 340 3 0 00000000 1
wr_mhartid      1 05 00000001 f14 3 0 00000000 1
rd_after_bad    2 00 00000000 340 3 0 0000001a 0
rd_misa         2 00 00000000 301 3 1 40000100 0
rd_mhartid      2 00 00000000 f14 3 1 00000000 0
rd_mvendorid    2 00 00000000 f11 3 1 00000000 0
rd_mcycle_off   2 00 00000000 b00 3 1 00000000 0
rd_minstret_off 2 00 00000000 b02 3 1 00000000 0
clr_inhibit_ir  7 04 00000000 320 3 0 ffffffff 0
ret_1           2 00 00000000 320 3 1 fffffffb 0
ret_2           2 00 00000000 340 3 1 0000001a 0
ret_3           2 00 00000000 301 3 1 40000100 0
rd_minstret     2 00 00000000 b02 3 0 00000003 0
rd_mcycle       2 00 00000000 b00 3 0 00000000 0
wr_mepc         1 06 12345678 341 3 0 00000000 0
rd_mepc_b2b     2 00 00000000 341 3 0 12345678 0

// File: csr_unit.f
logic/csr_pkg.sv
logic/csr_cmd_if.sv
logic/csr_access_if.sv
logic/csr_decode.sv
logic/csr_execute.sv
logic/csr_file.sv
logic/csr_respond.sv
logic/csr_unit.sv
verif/csr_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

LOG=sim.log

verilator --binary -f csr_unit.f --top-module csr_unit_tb -o csr_unit_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/csr_unit_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
fi
exit 1
